//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := lane_seq_tb
FILE_LIST := list.f
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard verif/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- addr_gen/vrf_addr_gen.sv
`timescale 1ns/1ps

module vrf_addr_gen (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  lane_seq_pkg::gen_mode_e          mode_i,
    input  logic [lane_seq_pkg::ADDR_W-1:0]  start_addr_i,
    input  lane_seq_pkg::sew_e               sew_i,
    output logic [lane_seq_pkg::ADDR_W-1:0]  addr_o,
    output logic [lane_seq_pkg::BWEN_W-1:0]  bwen_o,
    output logic [1:0]                       byte_sel_o
);
    import lane_seq_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        pos_q;        // Byte offset of the current element
    logic [2:0]        elem_bytes;
    logic [2:0]        pos_inc;
    logic              word_full;

    always_comb begin
        case (sew_i)
            SEW8:    elem_bytes = 3'd1;
            SEW16:   elem_bytes = 3'd2;
            default: elem_bytes = 3'd4;
        endcase
    end

    assign pos_inc   = {1'b0, pos_q} + elem_bytes;
    assign word_full = pos_inc[2];   // Carry out of the byte offset

    //////////////////////////////////////////////////////////////////////
    // Word address and position
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            pos_q  <= '0;
        end else begin
            case (mode_i)
                LOAD_START: begin
                    addr_q <= start_addr_i;
                    pos_q  <= '0;
                end
                STEP: begin
                    pos_q <= pos_inc[1:0];
                    if (word_full) begin
                        addr_q <= addr_q + 1'b1;
                    end
                end
                default: begin
                    addr_q <= addr_q;
                    pos_q  <= pos_q;
                end
            endcase
        end
    end

    // Byte enables for the element at pos_q
    always_comb begin
        case (sew_i)
            SEW8:    bwen_o = 4'b0001 << pos_q;
            SEW16:   bwen_o = pos_q[1] ? 4'b1100 : 4'b0011;
            default: bwen_o = 4'b1111;
        endcase
    end

    assign addr_o     = addr_q;
    assign byte_sel_o = pos_q;

endmodule

//--- common/lane_seq_pkg.sv
package lane_seq_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizing
    //////////////////////////////////////////////////////////////////////
    localparam int LANE_NUM   = 8;
    localparam int LANE_SHIFT = $clog2(LANE_NUM);   // vl to per-lane count
    localparam int MEM_DEPTH  = 512;                 // VRF words per lane
    localparam int ADDR_W     = $clog2(MEM_DEPTH);
    localparam int MAX_VL     = 256;
    localparam int VL_W       = $clog2(MAX_VL) + 1;  // Holds MAX_VL itself
    localparam int CNT_W      = 6;                   // Count of 32 plus delay of 31
    localparam int DELAY_W    = 5;
    localparam int OPMODE_W   = 6;
    localparam int IMM_W      = 5;
    localparam int XDATA_W    = 32;
    localparam int BWEN_W     = 4;                   // Bytes per VRF word
    localparam int RD_PORTS   = 2;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_e;

    typedef enum logic [1:0] {
        ARITH = 2'd0,
        STORE = 2'd1,
        LOAD  = 2'd2
    } inst_kind_e;

    // Command to one address generator
    typedef enum logic [1:0] {
        HOLD       = 2'd0,
        LOAD_START = 2'd1,
        STEP       = 2'd2
    } gen_mode_e;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        inst_kind_e                      kind;
        logic [VL_W-1:0]                 vl;
        sew_e                            sew;
        logic [DELAY_W-1:0]              inst_delay;   // ALU pipeline depth
        logic [ADDR_W-1:0]               waddr_start;
        logic [RD_PORTS-1:0][ADDR_W-1:0] raddr_start;
        logic [OPMODE_W-1:0]             alu_opmode;
        logic [IMM_W-1:0]                alu_imm;
        logic [XDATA_W-1:0]              alu_x_data;
    } vec_req_t;

    typedef struct packed {
        logic [OPMODE_W-1:0] opmode;
        logic [IMM_W-1:0]    imm;
        logic [XDATA_W-1:0]  x_data;
    } alu_ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [BWEN_W-1:0] bwen;
    } vrf_wr_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [1:0]        byte_sel;   // Element position inside the word
    } vrf_rd_t;

    typedef struct packed {
        logic [LANE_NUM-1:0][BWEN_W-1:0] bwen;
        logic                            last;
    } load_beat_t;

endpackage

//--- list.f
+incdir+verif
common/lane_seq_pkg.sv
addr_gen/vrf_addr_gen.sv
rtl/elem_counter.sv
rtl/lane_seq_fsm.sv
rtl/lane_seq_top.sv
verif/tb_clk_gen.sv
verif/lane_seq_tb.sv

//--- rtl/elem_counter.sv
`timescale 1ns/1ps

module elem_counter (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             clear_i,
    input  logic                             en_i,
    input  logic [lane_seq_pkg::CNT_W-1:0]   n_elems_i,
    input  logic [lane_seq_pkg::DELAY_W-1:0] delay_i,
    input  logic                             write_phase_en_i,
    output logic                             rd_phase_o,
    output logic                             wr_phase_o,
    output logic                             done_o
);
    import lane_seq_pkg::*;

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W:0]   cnt_ext;
    logic [CNT_W:0]   cnt_next;
    logic [CNT_W:0]   n_ext;
    logic [CNT_W:0]   delay_ext;
    logic [CNT_W:0]   wr_end;     // N + D, first count past the writes
    logic [CNT_W:0]   phase_end;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // One extra bit so N + D never wraps
    assign cnt_ext   = {1'b0, cnt_q};
    assign cnt_next  = cnt_ext + 1'b1;
    assign n_ext     = {1'b0, n_elems_i};
    assign delay_ext = {{(CNT_W + 1 - DELAY_W){1'b0}}, delay_i};
    assign wr_end    = n_ext + delay_ext;

    // STORE ends with its reads, ARITH with its writes
    assign phase_end = write_phase_en_i ? wr_end : n_ext;

    assign rd_phase_o = cnt_ext < n_ext;
    assign wr_phase_o = write_phase_en_i && (cnt_ext >= delay_ext) && (cnt_ext < wr_end);

    // Also covers an empty vector, which finishes on its first count
    assign done_o = cnt_next >= phase_end;

endmodule

//--- rtl/lane_seq_fsm.sv
`timescale 1ns/1ps

module lane_seq_fsm (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  lane_seq_pkg::vec_req_t            req_i,
    input  logic                              req_valid_i,
    output logic                              req_ready_o,
    input  logic                              rd_phase_i,
    input  logic                              wr_phase_i,
    input  logic                              done_i,
    input  logic                              load_valid_i,
    input  logic                              load_last_i,
    output logic                              load_ready_o,
    output logic                              cnt_clear_o,
    output logic                              cnt_en_o,
    output logic                              wr_phase_en_o,
    output logic [lane_seq_pkg::CNT_W-1:0]    n_elems_o,
    output logic [lane_seq_pkg::DELAY_W-1:0]  delay_o,
    output lane_seq_pkg::sew_e                sew_o,
    output lane_seq_pkg::gen_mode_e           wgen_mode_o,
    output lane_seq_pkg::gen_mode_e           rgen_mode_o,
    output logic                              rd_valid_o,
    output logic                              wr_valid_o,
    output logic                              store_valid_o,
    output lane_seq_pkg::alu_ctrl_t           alu_o
);
    import lane_seq_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,    // ARITH and STORE, paced by the element counter
        S_LOAD    // Paced by the load port
    } state_e;

    state_e           state_q, state_d;
    inst_kind_e       kind_q;
    logic [CNT_W-1:0] n_elems_q;
    logic [DELAY_W-1:0] delay_q;
    sew_e             sew_q;
    alu_ctrl_t        alu_q;
    logic             load_wr_q;   // Beat taken last cycle, write goes out now
    logic             accept;
    logic             beat_xfer;
    logic             run_rd;
    logic             run_wr;
    logic [VL_W:0]    vl_round;
    logic [VL_W:0]    n_calc;

    assign accept    = req_valid_i && req_ready_o;
    assign beat_xfer = load_valid_i && load_ready_o;

    // Per-lane count, vl / LANE_NUM rounded up
    assign vl_round = {1'b0, req_i.vl} + (VL_W + 1)'(LANE_NUM - 1);
    assign n_calc   = vl_round >> LANE_SHIFT;

    //////////////////////////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = (req_i.kind == LOAD) ? S_LOAD : S_RUN;
                end
            end
            S_RUN:   if (done_i) state_d = S_IDLE;
            S_LOAD:  if (beat_xfer && load_last_i) state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q   <= S_IDLE;
            kind_q    <= ARITH;
            load_wr_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            load_wr_q <= beat_xfer;
            if (accept) kind_q <= req_i.kind;
        end
    end

    // Instruction fields, sampled only on acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            n_elems_q    <= n_calc[CNT_W-1:0];
            delay_q      <= req_i.inst_delay;
            sew_q        <= (req_i.kind == LOAD) ? SEW32 : req_i.sew;  // One word per beat
            alu_q.opmode <= req_i.alu_opmode;
            alu_q.imm    <= req_i.alu_imm;
            alu_q.x_data <= req_i.alu_x_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counter and generator steering
    //////////////////////////////////////////////////////////////////////
    assign run_rd = (state_q == S_RUN) && rd_phase_i;
    assign run_wr = (state_q == S_RUN) && wr_phase_i;

    always_comb begin
        rgen_mode_o = HOLD;
        wgen_mode_o = HOLD;
        if (accept) begin
            rgen_mode_o = LOAD_START;
            wgen_mode_o = LOAD_START;
        end else begin
            if (run_rd) rgen_mode_o = STEP;
            if (run_wr || load_wr_q) wgen_mode_o = STEP;   // Advance after each write
        end
    end

    assign req_ready_o   = (state_q == S_IDLE) && !load_wr_q;  // Last load write pending
    assign load_ready_o  = (state_q == S_LOAD);
    assign cnt_clear_o   = accept;
    assign cnt_en_o      = (state_q == S_RUN);
    assign wr_phase_en_o = (kind_q == ARITH);
    assign n_elems_o     = n_elems_q;
    assign delay_o       = delay_q;
    assign sew_o         = sew_q;
    assign rd_valid_o    = run_rd;
    assign wr_valid_o    = run_wr || load_wr_q;
    assign store_valid_o = run_rd && (kind_q == STORE);
    assign alu_o         = alu_q;

endmodule

//--- rtl/lane_seq_top.sv
`timescale 1ns/1ps

module lane_seq_top (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  lane_seq_pkg::vec_req_t                              req_i,
    input  logic                                                req_valid_i,
    output logic                                                req_ready_o,
    input  lane_seq_pkg::load_beat_t                            load_i,
    input  logic                                                load_valid_i,
    output logic                                                load_ready_o,
    output lane_seq_pkg::vrf_wr_t [lane_seq_pkg::LANE_NUM-1:0]  wr_o,
    output lane_seq_pkg::vrf_rd_t [lane_seq_pkg::RD_PORTS-1:0]  rd_o,
    output logic                                                store_valid_o,
    output lane_seq_pkg::alu_ctrl_t                             alu_o
);
    import lane_seq_pkg::*;

    logic               cnt_clear;
    logic               cnt_en;
    logic               wr_phase_en;
    logic [CNT_W-1:0]   n_elems;
    logic [DELAY_W-1:0] delay;
    sew_e               sew;
    gen_mode_e          wgen_mode;
    gen_mode_e          rgen_mode;
    logic               rd_phase;
    logic               wr_phase;
    logic               done;
    logic               rd_valid;
    logic               wr_valid;

    logic [ADDR_W-1:0]                 waddr;
    logic [BWEN_W-1:0]                 wgen_bwen;
    logic [RD_PORTS-1:0][ADDR_W-1:0]   raddr;
    logic [RD_PORTS-1:0][1:0]          rbyte_sel;

    logic [LANE_NUM-1:0][BWEN_W-1:0]   beat_bwen_q;
    logic                              beat_vld_q;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////
    lane_seq_fsm u_fsm (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .rd_phase_i    (rd_phase),
        .wr_phase_i    (wr_phase),
        .done_i        (done),
        .load_valid_i  (load_valid_i),
        .load_last_i   (load_i.last),
        .load_ready_o  (load_ready_o),
        .cnt_clear_o   (cnt_clear),
        .cnt_en_o      (cnt_en),
        .wr_phase_en_o (wr_phase_en),
        .n_elems_o     (n_elems),
        .delay_o       (delay),
        .sew_o         (sew),
        .wgen_mode_o   (wgen_mode),
        .rgen_mode_o   (rgen_mode),
        .rd_valid_o    (rd_valid),
        .wr_valid_o    (wr_valid),
        .store_valid_o (store_valid_o),
        .alu_o         (alu_o)
    );

    elem_counter u_cnt (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .clear_i          (cnt_clear),
        .en_i             (cnt_en),
        .n_elems_i        (n_elems),
        .delay_i          (delay),
        .write_phase_en_i (wr_phase_en),
        .rd_phase_o       (rd_phase),
        .wr_phase_o       (wr_phase),
        .done_o           (done)
    );

    //////////////////////////////////////////////////////////////////////
    // Address generators
    //////////////////////////////////////////////////////////////////////
    vrf_addr_gen u_wgen (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mode_i       (wgen_mode),
        .start_addr_i (req_i.waddr_start),
        .sew_i        (sew),
        .addr_o       (waddr),
        .bwen_o       (wgen_bwen),
        .byte_sel_o   ()                // Writes carry bwen only
    );

    for (genvar p = 0; p < RD_PORTS; p++) begin : g_rgen
        vrf_addr_gen u_rgen (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .mode_i       (rgen_mode),
            .start_addr_i (req_i.raddr_start[p]),
            .sew_i        (sew),
            .addr_o       (raddr[p]),
            .bwen_o       (),           // Reads carry byte_sel only
            .byte_sel_o   (rbyte_sel[p])
        );
    end

    // Load beat is written out on the cycle after it is taken
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            beat_vld_q <= 1'b0;
        end else begin
            beat_vld_q <= load_valid_i && load_ready_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_valid_i && load_ready_o) begin
            beat_bwen_q <= load_i.bwen;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // VRF command assembly
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < LANE_NUM; i++) begin
            wr_o[i].valid = wr_valid;
            wr_o[i].addr  = waddr;                                   // Shared by all lanes
            wr_o[i].bwen  = beat_vld_q ? beat_bwen_q[i] : wgen_bwen;
        end
    end

    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rd_o[p].addr     = raddr[p];
            rd_o[p].byte_sel = rbyte_sel[p];
        end
        rd_o[0].valid = rd_valid;
        rd_o[1].valid = rd_valid && !store_valid_o;   // STORE uses one stream
    end

endmodule

//--- verif/lane_seq_checks.svh
`ifndef LANE_SEQ_CHECKS_SVH
`define LANE_SEQ_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Elements per lane, vl spread over all lanes and rounded up
function automatic int lane_elems(input int vl);
    return (vl + LANE_NUM - 1) / LANE_NUM;
endfunction

function automatic int sew_bytes(input sew_e s);
    case (s)
        SEW8:    return 1;
        SEW16:   return 2;
        default: return 4;
    endcase
endfunction

// Byte index of element k, split into word and offset
function automatic logic [ADDR_W-1:0] elem_addr(input logic [ADDR_W-1:0] start,
                                                input sew_e s, input int k);
    return ADDR_W'(int'(start) + (k * sew_bytes(s)) / BWEN_W);
endfunction

function automatic logic [1:0] elem_byte_sel(input sew_e s, input int k);
    return 2'((k * sew_bytes(s)) % BWEN_W);
endfunction

function automatic logic [BWEN_W-1:0] elem_bwen(input sew_e s, input int k);
    return BWEN_W'(((1 << sew_bytes(s)) - 1) << elem_byte_sel(s, k));
endfunction

function automatic vrf_rd_t expected_read(input logic valid, input logic [ADDR_W-1:0] start,
                                          input sew_e s, input int k);
    vrf_rd_t c;
    c = '0;
    if (valid) begin
        c.valid    = 1'b1;
        c.addr     = elem_addr(start, s, k);
        c.byte_sel = elem_byte_sel(s, k);
    end
    return c;
endfunction

function automatic vrf_wr_t expected_write(input logic valid, input logic [ADDR_W-1:0] start,
                                           input sew_e s, input int k);
    vrf_wr_t c;
    c = '0;
    if (valid) begin
        c.valid = 1'b1;
        c.addr  = elem_addr(start, s, k);
        c.bwen  = elem_bwen(s, k);
    end
    return c;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////
task automatic check_wr(input string what, input vrf_wr_t exp, input vrf_wr_t act);
    if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
        $display("Fail %s %s: expected valid=%0b addr=%h bwen=%b, actual valid=%0b addr=%h bwen=%b",
                 cur_test, what, exp.valid, exp.addr, exp.bwen, act.valid, act.addr, act.bwen);
        test_err++;
    end
endtask

task automatic check_rd(input string what, input vrf_rd_t exp, input vrf_rd_t act);
    if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
        $display("Fail %s %s: expected valid=%0b addr=%h sel=%0d, actual valid=%0b addr=%h sel=%0d",
                 cur_test, what, exp.valid, exp.addr, exp.byte_sel,
                 act.valid, act.addr, act.byte_sel);
        test_err++;
    end
endtask

task automatic check_alu(input string what, input alu_ctrl_t exp, input alu_ctrl_t act);
    if (exp !== act) begin
        $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
        test_err++;
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
        $display("Fail %s %s: expected %b, actual %b", cur_test, what, exp, act);
        test_err++;
    end
endtask

`endif

//--- verif/lane_seq_tb.sv
`timescale 1ns/1ps

module lane_seq_tb;
    import lane_seq_pkg::*;

    localparam int NUM_TESTS   = 40;
    localparam int MAX_BEATS   = 16;
    localparam int MAX_STALL   = 3;   // Idle load cycles before a beat is forced
    localparam int IDLE_GAP    = 3;
    localparam int TEST_CYCLES = IDLE_GAP + 2 + 32 + 31 + MAX_BEATS * (MAX_STALL + 1);
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + 200;

    logic                   clk;
    logic                   rst;
    vec_req_t               req;
    logic                   req_valid;
    logic                   req_ready;
    load_beat_t             load_beat;
    logic                   load_valid;
    logic                   load_ready;
    vrf_wr_t [LANE_NUM-1:0] wr;
    vrf_rd_t [RD_PORTS-1:0] rd;
    logic                   store_valid;
    alu_ctrl_t              alu;

    integer seed = 32'h9a56ebd3;
    string  cur_test;
    int     test_err;
    int     tests_passed;
    int     tests_failed;
    int     cycle_cnt;

    `include "lane_seq_checks.svh"

    tb_clk_gen #(.PERIOD(100), .RST_CYCLES(2)) u_clk_gen (.clk_o(clk), .rst_o(rst));

    lane_seq_top UUT (
        .clk_i         (clk),
        .rst_i         (rst),
        .req_i         (req),
        .req_valid_i   (req_valid),
        .req_ready_o   (req_ready),
        .load_i        (load_beat),
        .load_valid_i  (load_valid),
        .load_ready_o  (load_ready),
        .wr_o          (wr),
        .rd_o          (rd),
        .store_valid_o (store_valid),
        .alu_o         (alu)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic vec_req_t random_request();
        vec_req_t r;
        case (rand_below(3))
            0:       r.kind = ARITH;
            1:       r.kind = STORE;
            default: r.kind = LOAD;
        endcase
        case (rand_below(3))
            0:       r.sew = SEW8;
            1:       r.sew = SEW16;
            default: r.sew = SEW32;
        endcase
        r.vl             = VL_W'(1 + rand_below(MAX_VL));
        r.inst_delay     = DELAY_W'(1 + rand_below((1 << DELAY_W) - 1));  // Never zero
        r.waddr_start    = ADDR_W'(rand_below(MEM_DEPTH));
        r.raddr_start[0] = ADDR_W'(rand_below(MEM_DEPTH));
        r.raddr_start[1] = ADDR_W'(rand_below(MEM_DEPTH));
        r.alu_opmode     = OPMODE_W'(rand_below(1 << OPMODE_W));
        r.alu_imm        = IMM_W'(rand_below(1 << IMM_W));
        r.alu_x_data     = $random(seed);
        return r;
    endfunction

    function automatic load_beat_t random_beat(input logic last);
        load_beat_t b;
        for (int i = 0; i < LANE_NUM; i++) begin
            b.bwen[i] = BWEN_W'(rand_below(1 << BWEN_W));
        end
        b.last = last;
        return b;
    endfunction

    function automatic string kind_name(input inst_kind_e k);
        case (k)
            ARITH:   return "arith";
            STORE:   return "store";
            default: return "load";
        endcase
    endfunction

    task automatic finish_test(input int cycles);
        if (test_err == 0) begin
            tests_passed++;
            $display("Test %s: ok after %0d cycles", cur_test, cycles);
        end else begin
            tests_failed++;
            $display("Test %s: %0d mismatches", cur_test, test_err);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One instruction, checked cycle by cycle
    //////////////////////////////////////////////////////////////////////
    task automatic run_test(input int idx);
        vec_req_t                        r;
        alu_ctrl_t                       exp_alu;
        vrf_wr_t                         exp_wr;
        int                              n;
        int                              d;
        int                              last_cmd;
        int                              c;
        int                              beats_total;
        int                              beats_sent;
        int                              stall;
        int                              pend_idx;
        logic [LANE_NUM-1:0][BWEN_W-1:0] pend_bwen;
        logic                            pend_wr;
        logic                            cur_valid;
        logic                            xfer;
        logic                            last_taken;
        logic                            exp_ready;
        logic                            exp_load_ready;
        logic                            finished;
        load_beat_t                      beat;

        r           = random_request();
        n           = lane_elems(int'(r.vl));
        d           = int'(r.inst_delay);
        last_cmd    = (r.kind == ARITH) ? n + d : n;   // Cycle of the final command
        beats_total = 1 + rand_below(MAX_BEATS);
        cur_test    = $sformatf("test%0d_%s", idx, kind_name(r.kind));
        test_err    = 0;
        exp_alu.opmode = r.alu_opmode;
        exp_alu.imm    = r.alu_imm;
        exp_alu.x_data = r.alu_x_data;

        repeat (1 + rand_below(IDLE_GAP)) @(posedge clk);
        req       <= r;
        req_valid <= 1'b1;
        @(negedge clk);
        check_flag("req_ready idle", 1'b1, req_ready);
        while (req_ready !== 1'b1) @(negedge clk);
        @(posedge clk);                       // Acceptance edge
        req_valid <= 1'b0;
        req       <= random_request();       // Later changes must not leak in

        c          = 0;
        beats_sent = 0;
        stall      = 0;
        pend_idx   = 0;
        pend_bwen  = '0;
        cur_valid  = 1'b0;
        xfer       = 1'b0;
        last_taken = 1'b0;
        finished   = 1'b0;
        beat       = '0;
        while (!finished) begin
            // Beat taken on this edge is written next cycle
            pend_wr = xfer;
            if (xfer) begin
                pend_bwen = beat.bwen;
                pend_idx  = beats_sent;
                beats_sent++;
                if (beat.last) last_taken = 1'b1;
            end
            cur_valid = 1'b0;
            if (r.kind == LOAD && !last_taken) begin
                if (stall >= MAX_STALL || rand_below(2) == 1) begin
                    beat      = random_beat(beats_sent == beats_total - 1);
                    cur_valid = 1'b1;
                    stall     = 0;
                    load_beat <= beat;
                end else begin
                    stall++;
                    load_beat <= random_beat(1'b1);   // Junk while invalid
                end
            end
            load_valid <= cur_valid;

            @(negedge clk);
            c++;
            check_rd("rd0", expected_read(r.kind != LOAD && c <= n, r.raddr_start[0],
                                          r.sew, c - 1), rd[0]);
            check_rd("rd1", expected_read(r.kind == ARITH && c <= n, r.raddr_start[1],
                                          r.sew, c - 1), rd[1]);
            check_flag("store_valid", r.kind == STORE && c <= n, store_valid);
            for (int i = 0; i < LANE_NUM; i++) begin
                if (r.kind == LOAD) begin
                    exp_wr.valid = pend_wr;
                    exp_wr.addr  = ADDR_W'(int'(r.waddr_start) + pend_idx);
                    exp_wr.bwen  = pend_bwen[i];
                end else begin
                    exp_wr = expected_write(r.kind == ARITH && c > d && c <= n + d,
                                            r.waddr_start, r.sew, c - 1 - d);
                end
                check_wr($sformatf("wr lane %0d", i), exp_wr, wr[i]);
            end
            if (r.kind == LOAD) begin
                exp_ready = last_taken && !pend_wr;
            end else begin
                exp_ready = c > last_cmd;
            end
            exp_load_ready = (r.kind == LOAD) && !last_taken;
            check_flag("req_ready", exp_ready, req_ready);
            check_flag("load_ready", exp_load_ready, load_ready);
            check_alu("alu", exp_alu, alu);
            xfer = cur_valid && exp_load_ready;
            if (exp_ready) begin
                finished = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
        finish_test(c);
    endtask

    initial begin
        req          = '0;
        req_valid    = 1'b0;
        load_beat    = '0;
        load_valid   = 1'b0;
        test_err     = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_cnt    = 0;

        wait (rst === 1'b1);
        @(negedge clk);
        cur_test = "reset";
        check_flag("req_ready", 1'b1, req_ready);
        check_flag("load_ready", 1'b0, load_ready);
        check_flag("store_valid", 1'b0, store_valid);
        check_flag("rd0 valid", 1'b0, rd[0].valid);
        check_flag("rd1 valid", 1'b0, rd[1].valid);
        for (int i = 0; i < LANE_NUM; i++) begin
            check_flag($sformatf("wr lane %0d valid", i), 1'b0, wr[i].valid);
        end
        finish_test(0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Tests %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Active low, released on a rising edge
    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule
